// ==== design/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    // pixel and weight formats
    localparam int PIX_W  = 8;
    localparam int WGT_W  = 8;
    localparam int LANES  = 2;
    localparam int WORD_W = PIX_W * LANES;

    // image geometry, LINE_W must be at least 3
    localparam int LINE_W = 16;
    localparam int COL_W  = $clog2(LINE_W);

    // arithmetic
    localparam int TAPS      = 9;
    localparam int PROD_W    = PIX_W + WGT_W + 1;
    localparam int SUM_W     = 20;
    localparam int RND_SHIFT = 8;
    localparam int RND_BIAS  = 1 << (RND_SHIFT - 1);
    localparam int PIX_MAX   = (1 << PIX_W) - 1;

    typedef logic signed [WGT_W-1:0] weight_t;

    // pix[1] is the upper byte, pix[0] the lower
    typedef struct packed {
        logic [LANES-1:0][PIX_W-1:0] pix;
    } lane_pair_s;

    typedef union packed {
        logic [WORD_W-1:0] raw;
        lane_pair_s        lane;
    } pix_pair_u;

    // one image column, top is the oldest row
    typedef struct packed {
        pix_pair_u top;
        pix_pair_u middle;
        pix_pair_u bottom;
    } column_s;

    typedef struct packed {
        column_s left;
        column_s centre;
        column_s right;
    } window_s;

    // w[0] is top-left, row-major
    typedef struct packed {
        weight_t [TAPS-1:0] w;
    } kernel_s;

endpackage

`default_nettype wire

// ==== design/conv_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pixel_valid,
    input  conv_pkg::pix_pair_u               pixel_data,
    input  logic                              knl_wr_en,
    input  logic [3:0]                        knl_wr_addr,
    input  logic signed [conv_pkg::WGT_W-1:0] knl_wr_data,
    output logic                              out_valid,
    output conv_pkg::pix_pair_u               out_data
);
    import conv_pkg::*;

    logic    col_valid;
    logic    col_first;
    logic    rows_ready;
    column_s col;
    logic    win_valid;
    window_s win;
    kernel_s kernel;

    // row storage, one column per accepted pixel
    line_buffer u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .col_valid   (col_valid),
        .col_first   (col_first),
        .col         (col),
        .rows_ready  (rows_ready)
    );

    window_shift u_window_shift (
        .clk        (clk),
        .rst        (rst),
        .col_valid  (col_valid),
        .col_first  (col_first),
        .rows_ready (rows_ready),
        .col        (col),
        .win_valid  (win_valid),
        .win        (win)
    );

    kernel_store u_kernel_store (
        .clk         (clk),
        .rst         (rst),
        .knl_wr_en   (knl_wr_en),
        .knl_wr_addr (knl_wr_addr),
        .knl_wr_data (knl_wr_data),
        .kernel      (kernel)
    );

    // three-stage multiply-accumulate for both lanes
    mac_array u_mac_array (
        .clk       (clk),
        .rst       (rst),
        .win_valid (win_valid),
        .win       (win),
        .kernel    (kernel),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== design/kernel_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module kernel_store (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              knl_wr_en,
    input  logic [3:0]                        knl_wr_addr,
    input  logic signed [conv_pkg::WGT_W-1:0] knl_wr_data,
    output conv_pkg::kernel_s                 kernel
);
    import conv_pkg::*;

    kernel_s weights;

    // one weight per write, decoded by tap index
    always_ff @(posedge clk) begin
        if (rst) begin
            weights <= '0;
        end else if (knl_wr_en) begin
            for (int t = 0; t < TAPS; t++) begin
                if (knl_wr_addr == 4'(t)) begin
                    weights.w[t] <= knl_wr_data;
                end
            end
        end
    end

    assign kernel = weights;

    a_addr_range: assert property (
        @(posedge clk) disable iff (rst)
        knl_wr_en |-> (knl_wr_addr < 4'(TAPS))
    );

endmodule

`default_nettype wire

// ==== design/line_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                pixel_valid,
    input  conv_pkg::pix_pair_u pixel_data,
    output logic                col_valid,
    output logic                col_first,
    output conv_pkg::column_s   col,
    output logic                rows_ready
);
    import conv_pkg::*;

    // two previous rows, oldest on top
    logic [WORD_W-1:0] row_top [LINE_W];
    logic [WORD_W-1:0] row_mid [LINE_W];

    logic [COL_W-1:0] col_cnt;
    logic [1:0]       row_cnt;
    logic             last_col;

    assign last_col = (col_cnt == COL_W'(LINE_W - 1));

    //////////////////////////////////////////////////
    // column and row position

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (pixel_valid) begin
            if (last_col) begin
                col_cnt <= '0;
                // saturates once two full rows are stored
                if (row_cnt != 2'd2) begin
                    row_cnt <= row_cnt + 2'd1;
                end
            end else begin
                col_cnt <= col_cnt + COL_W'(1);
            end
        end
    end

    // flags travel with the column they describe
    always_ff @(posedge clk) begin
        if (rst) begin
            col_valid  <= 1'b0;
            col_first  <= 1'b0;
            rows_ready <= 1'b0;
        end else begin
            col_valid <= pixel_valid;
            if (pixel_valid) begin
                col_first  <= (col_cnt == '0);
                rows_ready <= (row_cnt == 2'd2);
            end
        end
    end

    //////////////////////////////////////////////////
    // row cascade

    // middle row moves up to top, new pixel takes its slot
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            col.top.raw      <= row_top[col_cnt];
            col.middle.raw   <= row_mid[col_cnt];
            col.bottom       <= pixel_data;
            row_top[col_cnt] <= row_mid[col_cnt];
            row_mid[col_cnt] <= pixel_data.raw;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(pixel_valid)
    );

endmodule

`default_nettype wire

// ==== design/mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_array (
    input  logic                clk,
    input  logic                rst,
    input  logic                win_valid,
    input  conv_pkg::window_s   win,
    input  conv_pkg::kernel_s   kernel,
    output logic                out_valid,
    output conv_pkg::pix_pair_u out_data
);
    import conv_pkg::*;

    // window flattened to tap order, 0 is top-left
    pix_pair_u taps [TAPS];

    logic signed [PROD_W-1:0] prod_q   [LANES][TAPS];
    logic signed [SUM_W-1:0]  tree_sum [LANES];
    logic signed [SUM_W-1:0]  sum_q    [LANES];
    logic signed [SUM_W-1:0]  shifted  [LANES];
    logic [PIX_W-1:0]         sat      [LANES];
    logic                     prod_valid;
    logic                     sum_valid;

    assign taps[0] = win.left.top;
    assign taps[1] = win.centre.top;
    assign taps[2] = win.right.top;
    assign taps[3] = win.left.middle;
    assign taps[4] = win.centre.middle;
    assign taps[5] = win.right.middle;
    assign taps[6] = win.left.bottom;
    assign taps[7] = win.centre.bottom;
    assign taps[8] = win.right.bottom;

    //////////////////////////////////////////////////
    // stage 1: products

    // unsigned pixel times signed weight, both lanes share the kernel
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            for (int t = 0; t < TAPS; t++) begin
                prod_q[l][t] <= $signed({1'b0, taps[t].lane.pix[l]})
                                * $signed(kernel.w[t]);
            end
        end
    end

    //////////////////////////////////////////////////
    // stage 2: adder tree

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            tree_sum[l] = '0;
            for (int t = 0; t < TAPS; t++) begin
                tree_sum[l] = tree_sum[l] + SUM_W'(prod_q[l][t]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            sum_q[l] <= tree_sum[l];
        end
    end

    //////////////////////////////////////////////////
    // stage 3: round, shift, saturate

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            // round half up before the arithmetic shift
            shifted[l] = (sum_q[l] + SUM_W'(RND_BIAS)) >>> RND_SHIFT;
            if (shifted[l] < 0) begin
                sat[l] = '0;
            end else if (shifted[l] > PIX_MAX) begin
                sat[l] = PIX_W'(PIX_MAX);
            end else begin
                sat[l] = shifted[l][PIX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            out_data.lane.pix[l] <= sat[l];
        end
    end

    // valid alongside each stage
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            sum_valid  <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            prod_valid <= win_valid;
            sum_valid  <= prod_valid;
            out_valid  <= sum_valid;
        end
    end

    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        out_valid == $past(win_valid, 3)
    );

endmodule

`default_nettype wire

// ==== design/window_shift.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_shift (
    input  logic              clk,
    input  logic              rst,
    input  logic              col_valid,
    input  logic              col_first,
    input  logic              rows_ready,
    input  conv_pkg::column_s col,
    output logic              win_valid,
    output conv_pkg::window_s win
);

    // columns of the current row held before this one, capped at 2
    logic [1:0] col_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt   <= '0;
            win_valid <= 1'b0;
        end else begin
            // third or later column of a row below two stored rows
            win_valid <= col_valid && rows_ready && !col_first
                         && (col_cnt == 2'd2);
            if (col_valid) begin
                if (col_first) begin
                    col_cnt <= 2'd1;
                end else if (col_cnt != 2'd2) begin
                    col_cnt <= col_cnt + 2'd1;
                end
            end
        end
    end

    // newest column enters on the right
    always_ff @(posedge clk) begin
        if (col_valid) begin
            win.left   <= win.centre;
            win.centre <= win.right;
            win.right  <= col;
        end
    end

endmodule

`default_nettype wire

// ==== dv/conv_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_tb;
    import conv_pkg::*;

    localparam int          LATENCY    = 5;
    localparam int          WAIT_MAX   = 200;
    localparam int          FRAME_ROWS = 5;
    localparam logic [31:0] LFSR_SEED  = 32'hc5c8;
    localparam logic [31:0] LFSR_POLY  = 32'h80200003;

    logic                    clk;
    logic                    rst;
    logic                    reset_req;
    logic                    pixel_valid;
    pix_pair_u               pixel_data;
    logic                    knl_wr_en;
    logic [3:0]              knl_wr_addr;
    logic signed [WGT_W-1:0] knl_wr_data;
    logic                    out_valid;
    pix_pair_u               out_data;

    logic [31:0]      lfsr;
    weight_t          wgt_copy [TAPS];
    // last three rows, indexed by row modulo 3
    logic [PIX_W-1:0] img [3][LINE_W][LANES];
    int               row_pos;
    int               col_pos;
    logic [LATENCY-1:0] exp_v;
    pix_pair_u        exp_d [LATENCY];
    int               windows_sent;
    int               results_seen;
    int               max_in_flight;

    tb_clock u_clock (
        .reset_req (reset_req),
        .clk       (clk),
        .rst       (rst)
    );

    conv_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .knl_wr_en   (knl_wr_en),
        .knl_wr_addr (knl_wr_addr),
        .knl_wr_data (knl_wr_data),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    //////////////////////////////////////////////////
    // helpers

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // galois step, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // nine taps around (row - 1, col - 1), rounded and clamped
    function automatic logic [PIX_W-1:0] expected_lane(int lane, int row, int col);
        int acc;
        acc = 0;
        for (int dr = 0; dr < 3; dr++) begin
            for (int dc = 0; dc < 3; dc++) begin
                acc += int'(img[(row - 2 + dr) % 3][col - 2 + dc][lane])
                       * int'(wgt_copy[dr * 3 + dc]);
            end
        end
        acc = (acc + 128) >>> 8;
        if (acc < 0) begin
            return '0;
        end else if (acc > 255) begin
            return 8'hff;
        end
        return 8'(acc);
    endfunction

    //////////////////////////////////////////////////
    // reference model

    always @(posedge clk) begin
        pix_pair_u res;
        logic      done;
        res  = '0;
        done = 1'b0;
        if (rst) begin
            row_pos = 0;
            col_pos = 0;
            exp_v <= '0;
        end else begin
            if (pixel_valid) begin
                for (int l = 0; l < LANES; l++) begin
                    img[row_pos % 3][col_pos][l] = pixel_data.lane.pix[l];
                end
                done = (row_pos >= 2) && (col_pos >= 2);
                if (done) begin
                    for (int l = 0; l < LANES; l++) begin
                        res.lane.pix[l] = expected_lane(l, row_pos, col_pos);
                    end
                    windows_sent++;
                end
                if (col_pos == LINE_W - 1) begin
                    col_pos = 0;
                    row_pos++;
                end else begin
                    col_pos++;
                end
            end
            exp_v <= {exp_v[LATENCY-2:0], done};
        end
        exp_d[0] <= res;
        for (int k = 1; k < LATENCY; k++) begin
            exp_d[k] <= exp_d[k-1];
        end
    end

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            results_seen++;
        end
        // windows taken by the DUT whose result has not come out yet
        if (windows_sent - results_seen > max_in_flight) begin
            max_in_flight = windows_sent - results_seen;
        end
    end

    a_out_valid: assert property (
        @(posedge clk) disable iff (rst)
        out_valid == exp_v[LATENCY-1]
    ) else stop_on_error($sformatf("ERR %0t out_valid expected %0b got %0b",
        $time, $sampled(exp_v[LATENCY-1]), $sampled(out_valid)));

    a_lane0: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> out_data.lane.pix[0] == exp_d[LATENCY-1].lane.pix[0]
    ) else stop_on_error($sformatf("ERR %0t out_data.lane.pix[0] expected %02h got %02h",
        $time, $sampled(exp_d[LATENCY-1].lane.pix[0]), $sampled(out_data.lane.pix[0])));

    a_lane1: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> out_data.lane.pix[1] == exp_d[LATENCY-1].lane.pix[1]
    ) else stop_on_error($sformatf("ERR %0t out_data.lane.pix[1] expected %02h got %02h",
        $time, $sampled(exp_d[LATENCY-1].lane.pix[1]), $sampled(out_data.lane.pix[1])));

    //////////////////////////////////////////////////
    // stimulus

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (rst && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            stop_on_error("reset did not release within the timeout");
        end
    endtask

    task automatic restart_frame();
        @(negedge clk);
        reset_req = 1'b1;
        @(posedge clk);
        reset_req = 1'b0;
        wait_reset_done();
    endtask

    // mode 0 random, 1 large positive, 2 most negative
    task automatic load_kernel(int mode);
        weight_t w;
        for (int t = 0; t < TAPS; t++) begin
            case (mode)
                1: w = weight_t'(127);
                2: w = weight_t'(-128);
                default: w = weight_t'(int'(take_bits(6)) - 32);
            endcase
            @(negedge clk);
            knl_wr_en   = 1'b1;
            knl_wr_addr = 4'(t);
            knl_wr_data = w;
            wgt_copy[t] = w;
        end
        @(negedge clk);
        knl_wr_en = 1'b0;
    endtask

    // mode 0 random, 1 lane 1 white and lane 0 black, 2 all white
    task automatic send_frame(int img_mode, bit gaps);
        pix_pair_u p;
        int        gap;
        for (int i = 0; i < FRAME_ROWS * LINE_W; i++) begin
            case (img_mode)
                1: p.raw = 16'hff00;
                2: p.raw = 16'hffff;
                default: p.raw = 16'(take_bits(16));
            endcase
            gap = gaps ? int'(take_bits(2)) : 0;
            @(negedge clk);
            pixel_valid = 1'b1;
            pixel_data  = p;
            repeat (gap) begin
                @(negedge clk);
                pixel_valid     = 1'b0;
                pixel_data.raw  = 16'(take_bits(16));
            end
        end
        @(negedge clk);
        pixel_valid = 1'b0;
    endtask

    task automatic drain_results();
        int n;
        n = 0;
        while (exp_v != '0 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (exp_v != '0) begin
            stop_on_error("results still pending after the timeout");
        end
        a_count: assert (results_seen == windows_sent)
            else stop_on_error($sformatf("%0d results seen for %0d complete windows",
                results_seen, windows_sent));
    endtask

    initial begin
        pixel_valid   = 1'b0;
        pixel_data    = '0;
        knl_wr_en     = 1'b0;
        knl_wr_addr   = '0;
        knl_wr_data   = '0;
        reset_req     = 1'b0;
        lfsr          = LFSR_SEED;
        windows_sent  = 0;
        results_seen  = 0;
        max_in_flight = 0;
        wait_reset_done();

        // random frame, back to back
        load_kernel(0);
        send_frame(0, 1'b0);
        drain_results();
        a_overlap: assert (max_in_flight >= 2)
            else stop_on_error("results never overlapped in the pipeline");

        // new kernel, random idle gaps
        restart_frame();
        load_kernel(0);
        send_frame(0, 1'b1);
        drain_results();

        // saturation high and low
        restart_frame();
        load_kernel(1);
        send_frame(1, 1'b0);
        send_frame(2, 1'b0);
        drain_results();
        restart_frame();
        load_kernel(2);
        send_frame(2, 1'b1);
        drain_results();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    localparam int HALF_NS    = 4;
    localparam int RST_CYCLES = 16;

    int rst_cnt = RST_CYCLES;

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    // power-on reset, reloaded on each request
    always @(negedge clk or posedge reset_req) begin
        if (reset_req) begin
            rst_cnt <= RST_CYCLES;
        end else if (rst_cnt != 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst = (rst_cnt != 0);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run, exit status follows the simulation
verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tb -f sim.f -o conv_tb_sim \
    && ./obj_dir/conv_tb_sim \
    || exit 1

// ==== sim.f ====
design/conv_pkg.sv
design/line_buffer.sv
design/window_shift.sv
design/kernel_store.sv
design/mac_array.sv
design/conv_top.sv
dv/tb_clock.sv
dv/conv_tb.sv
